// File: list.f
logic/cache_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/uncached_port.sv
logic/bus_arbiter.sv
logic/cache_top.sv
bench/mem_model.sv
bench/tb_cache_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the cache block testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tb_cache_top -o tb_cache_top &&
  ./obj_dir/tb_cache_top ||
  { echo "cache block simulation failed"; exit 1; }

// File: bench/tb_cache_top.sv
////////////////////
// testbench for the cache block
// shadow memory reference, concurrent core traffic
////////////////////
`timescale 1ns/10ps

module tb_cache_top;

  localparam int unsigned      MAX_CYCLES = 20000;
  localparam cache_pkg::addr_t CODE_BASE  = 32'h8000_0000;
  localparam cache_pkg::addr_t DATA_BASE  = 32'h8000_4000;
  localparam cache_pkg::addr_t DPERI_BASE = 32'h1000_0000;
  localparam cache_pkg::addr_t IPERI_BASE = 32'h2000_0000;

  logic                clk;
  logic                i_rst;
  logic                i_ireq;
  cache_pkg::addr_t    i_iaddr;
  logic                o_iack;
  cache_pkg::inst_t    o_idata;
  logic                i_dreq;
  cache_pkg::addr_t    i_daddr;
  logic                i_dwe;
  cache_pkg::size_e    i_dsize;
  cache_pkg::word_t    i_dwdata;
  logic                o_dack;
  cache_pkg::word_t    o_drdata;
  logic                i_fence_req;
  logic                o_fence_ack;
  logic                bus_valid;
  cache_pkg::bus_req_t bus_req;
  logic                bus_ready;
  cache_pkg::line_t    bus_rdata;

  logic [7:0]  shadow [cache_pkg::addr_t];
  int unsigned cycles = 0;

  cache_top #(.ICACHE_LINES(16), .DCACHE_LINES(16)) u_dut (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ireq      (i_ireq),
    .i_iaddr     (i_iaddr),
    .o_iack      (o_iack),
    .o_idata     (o_idata),
    .i_dreq      (i_dreq),
    .i_daddr     (i_daddr),
    .i_dwe       (i_dwe),
    .i_dsize     (i_dsize),
    .i_dwdata    (i_dwdata),
    .o_dack      (o_dack),
    .o_drdata    (o_drdata),
    .i_fence_req (i_fence_req),
    .o_fence_ack (o_fence_ack),
    .o_bus_valid (bus_valid),
    .o_bus_req   (bus_req),
    .i_bus_ready (bus_ready),
    .i_bus_rdata (bus_rdata)
  );

  mem_model u_mem (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (bus_valid),
    .i_req   (bus_req),
    .o_ready (bus_ready),
    .o_rdata (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////
  // reference model

  function automatic logic [7:0] fill_byte(cache_pkg::addr_t a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24];
  endfunction

  // memory is always current since every store goes through
  function automatic cache_pkg::word_t ref_read(cache_pkg::addr_t a);
    cache_pkg::word_t w;
    cache_pkg::addr_t p;
    for (int b = 0; b < 8; b++) begin
      p = {a[31:3], 3'b000} + cache_pkg::addr_t'(b);
      w[b*8 +: 8] = shadow.exists(p) ? shadow[p] : fill_byte(p);
    end
    return w;
  endfunction

  task automatic write_shadow(cache_pkg::addr_t a, cache_pkg::size_e sz, cache_pkg::word_t wd);
    int n;
    n = 1 << sz;
    for (int b = 0; b < n; b++) begin
      shadow[a + cache_pkg::addr_t'(b)] = wd[b*8 +: 8];
    end
  endtask

  task automatic check_eq(logic [63:0] got, logic [63:0] exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s, got %h expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  always @(negedge clk) begin : compare
    cache_pkg::word_t exp_w;
    if (i_rst) begin
      if (cycles > 0) begin
        check_eq(64'(o_iack), 64'd0, "iack during reset");
        check_eq(64'(o_dack), 64'd0, "dack during reset");
        check_eq(64'(bus_valid), 64'd0, "bus valid during reset");
      end
    end else begin
      if (o_dack) begin
        if (i_dwe) begin
          write_shadow(i_daddr, i_dsize, i_dwdata);
        end else begin
          check_eq(o_drdata, ref_read(i_daddr), "data read");
        end
      end
      if (o_iack) begin
        exp_w = ref_read(i_iaddr);
        check_eq(64'(o_idata), 64'(i_iaddr[2] ? exp_w[63:32] : exp_w[31:0]), "fetch");
      end
      // bus shape per window
      if (bus_valid && bus_ready) begin
        if ((bus_req.addr >= cache_pkg::PERI_LO) && (bus_req.addr <= cache_pkg::PERI_HI)) begin
          check_eq(64'(bus_req.line), 64'd0, "peripheral access as line");
        end
        if ((bus_req.addr >= cache_pkg::MEM_BASE) && (bus_req.op == cache_pkg::BUS_READ)) begin
          check_eq(64'(bus_req.line), 64'd1, "memory read not a line");
          check_eq(64'(bus_req.addr[4:0]), 64'd0, "line read misaligned");
        end
      end
    end
  end

  ////////////////////
  // core-side drivers

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic data_access(cache_pkg::addr_t a, logic we, cache_pkg::size_e sz,
                             cache_pkg::word_t wd);
    i_dreq   = 1'b1;
    i_daddr  = a;
    i_dwe    = we;
    i_dsize  = sz;
    i_dwdata = wd;
    do @(negedge clk); while (!o_dack);
    next_cycle();
    i_dreq = 1'b0;
  endtask

  task automatic fetch(cache_pkg::addr_t a);
    i_ireq  = 1'b1;
    i_iaddr = a;
    do @(negedge clk); while (!o_iack);
    next_cycle();
    i_ireq = 1'b0;
  endtask

  task automatic fence_icache();
    i_fence_req = 1'b1;
    do @(negedge clk); while (!o_fence_ack);
    next_cycle();
    i_fence_req = 1'b0;
  endtask

  // random sized access, aligned to its size
  task automatic random_data_op(cache_pkg::addr_t base, int unsigned span);
    cache_pkg::size_e sz;
    cache_pkg::addr_t a;
    sz = cache_pkg::size_e'($urandom % 4);
    a  = (base + ($urandom % span)) & ~((32'd1 << sz) - 32'd1);
    data_access(a, 1'($urandom % 2), sz, {$urandom, $urandom});
  endtask

  task automatic random_fetch(cache_pkg::addr_t base, int unsigned span);
    fetch(base + (($urandom % span) & ~32'd3));
  endtask

  initial begin
    void'($urandom(32'hd6ce4792));
    i_rst       = 1'b1;
    i_ireq      = 1'b0;
    i_iaddr     = CODE_BASE;
    i_dreq      = 1'b0;
    i_daddr     = DATA_BASE;
    i_dwe       = 1'b0;
    i_dsize     = cache_pkg::SZ_D;
    i_dwdata    = '0;
    i_fence_req = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    i_rst = 1'b0;

    // every size, then one set with four tags
    for (int s = 0; s < 4; s++) begin
      data_access(DATA_BASE + 32'h10, 1'b1, cache_pkg::size_e'(s), {$urandom, $urandom});
      data_access(DATA_BASE + 32'h10, 1'b0, cache_pkg::SZ_D, '0);
    end
    for (int k = 0; k < 16; k++) begin
      data_access(DATA_BASE + 32'h48 + 32'(k % 4) * 32'd512, 1'b0, cache_pkg::SZ_D, '0);
    end
    repeat (60) random_data_op(DATA_BASE, 2048);

    // fetches, both halves, hits and conflict misses
    for (int k = 0; k < 8; k++) begin
      fetch(CODE_BASE + 32'h20 + 32'(k) * 32'd4);
    end
    for (int k = 0; k < 8; k++) begin
      fetch(CODE_BASE + 32'h14 + 32'(k % 2) * 32'd512);
    end
    repeat (32) random_fetch(CODE_BASE, 1024);

    // peripheral window through both channels
    repeat (20) random_data_op(DPERI_BASE, 256);
    repeat (10) random_fetch(IPERI_BASE, 256);

    // fence.i makes a store visible to fetch
    fetch(CODE_BASE + 32'h84);
    fetch(CODE_BASE + 32'h84);
    data_access(CODE_BASE + 32'h84, 1'b1, cache_pkg::SZ_W, 64'h0000_0000_0badc0de);
    fence_icache();
    fetch(CODE_BASE + 32'h84);

    fork
      repeat (200) begin
        if ($urandom % 5 == 0) random_data_op(DPERI_BASE, 256);
        else random_data_op(DATA_BASE, 2048);
        if ($urandom % 8 == 0) next_cycle();
      end
      repeat (200) begin
        if ($urandom % 7 == 0) random_fetch(IPERI_BASE, 256);
        else random_fetch(CODE_BASE, 1024);
        if ($urandom % 8 == 0) next_cycle();
      end
    join

    repeat (4) next_cycle();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: bench/mem_model.sv
////////////////////
// bus slave model with random ready latency
////////////////////
`timescale 1ns/10ps

module mem_model (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  cache_pkg::bus_req_t i_req,
  output logic                o_ready,
  output cache_pkg::line_t    o_rdata
);

  logic [7:0]  mem [cache_pkg::addr_t];
  int unsigned wait_cnt;
  logic        fire;

  // contents of a byte never written
  function automatic logic [7:0] fill_byte(cache_pkg::addr_t a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24];
  endfunction

  function automatic logic [7:0] read_byte(cache_pkg::addr_t a);
    return mem.exists(a) ? mem[a] : fill_byte(a);
  endfunction

  function automatic cache_pkg::line_t read_data(cache_pkg::bus_req_t r);
    cache_pkg::line_t d;
    cache_pkg::addr_t base;
    int               n;
    d    = '0;
    base = r.line ? {r.addr[31:5], 5'b00000} : {r.addr[31:3], 3'b000};
    n    = r.line ? 32 : 8;
    for (int b = 0; b < n; b++) begin
      d[b*8 +: 8] = read_byte(base + cache_pkg::addr_t'(b));
    end
    return d;
  endfunction

  task automatic write_word(cache_pkg::bus_req_t r);
    cache_pkg::addr_t base;
    base = {r.addr[31:3], 3'b000};
    for (int b = 0; b < 8; b++) begin
      if (r.wstrb[b]) begin
        mem[base + cache_pkg::addr_t'(b)] = r.wdata[b*8 +: 8];
      end
    end
  endtask

  initial begin
    o_ready  = 1'b0;
    o_rdata  = '0;
    wait_cnt = 0;
    fire     = 1'b0;
    forever begin
      // transaction completes at the coming edge
      @(negedge clk);
      fire = i_valid && o_ready && !i_rst;
      if (fire && (i_req.op == cache_pkg::BUS_WRITE)) begin
        write_word(i_req);
      end
      @(posedge clk);
      #2;
      if (i_rst || fire) begin
        o_ready  = 1'b0;
        wait_cnt = $urandom % 4;
      end else if (i_valid && !o_ready) begin
        if (wait_cnt == 0) begin
          o_ready = 1'b1;
          o_rdata = read_data(i_req);
        end else begin
          wait_cnt--;
        end
      end
    end
  end

endmodule

// File: logic/cache_top.sv
////////////////////
// cache block top level
// window routing, response muxing, bus sharing
////////////////////
`timescale 1ns/10ps

module cache_top #(
  parameter int ICACHE_LINES = 16,
  parameter int DCACHE_LINES = 16
) (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_ireq,
  input  cache_pkg::addr_t    i_iaddr,
  output logic                o_iack,
  output cache_pkg::inst_t    o_idata,
  input  logic                i_dreq,
  input  cache_pkg::addr_t    i_daddr,
  input  logic                i_dwe,
  input  cache_pkg::size_e    i_dsize,
  input  cache_pkg::word_t    i_dwdata,
  output logic                o_dack,
  output cache_pkg::word_t    o_drdata,
  input  logic                i_fence_req,
  output logic                o_fence_ack,
  output logic                o_bus_valid,
  output cache_pkg::bus_req_t o_bus_req,
  input  logic                i_bus_ready,
  input  cache_pkg::line_t    i_bus_rdata
);

  logic fetch_peri, fetch_mem, data_peri, data_mem;

  logic             ic_ack, dc_ack, un_iack, un_dack;
  cache_pkg::inst_t ic_data, un_idata;
  cache_pkg::word_t dc_rdata, un_drdata;

  logic                [cache_pkg::NUM_MASTERS-1:0] mst_valid;
  logic                [cache_pkg::NUM_MASTERS-1:0] mst_ready;
  cache_pkg::bus_req_t [cache_pkg::NUM_MASTERS-1:0] mst_req;

  ////////////////////
  // address windows

  assign fetch_peri = cache_pkg::in_peri(i_iaddr);
  assign fetch_mem  = cache_pkg::in_mem(i_iaddr);
  assign data_peri  = cache_pkg::in_peri(i_daddr);
  assign data_mem   = cache_pkg::in_mem(i_daddr);

  icache #(.LINES(ICACHE_LINES)) u_icache (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (i_ireq && fetch_mem),
    .i_addr      (i_iaddr),
    .i_fence_req (i_fence_req),
    .i_bus_ready (mst_ready[cache_pkg::M_ICACHE]),
    .i_bus_rdata (i_bus_rdata),
    .o_ack       (ic_ack),
    .o_data      (ic_data),
    .o_fence_ack (o_fence_ack),
    .o_bus_valid (mst_valid[cache_pkg::M_ICACHE]),
    .o_bus_req   (mst_req[cache_pkg::M_ICACHE])
  );

  dcache #(.LINES(DCACHE_LINES)) u_dcache (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (i_dreq && data_mem),
    .i_addr      (i_daddr),
    .i_we        (i_dwe),
    .i_size      (i_dsize),
    .i_wdata     (i_dwdata),
    .i_bus_ready (mst_ready[cache_pkg::M_DCACHE]),
    .i_bus_rdata (i_bus_rdata),
    .o_ack       (dc_ack),
    .o_rdata     (dc_rdata),
    .o_bus_valid (mst_valid[cache_pkg::M_DCACHE]),
    .o_bus_req   (mst_req[cache_pkg::M_DCACHE])
  );

  uncached_port u_uncached (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ireq      (i_ireq && fetch_peri),
    .i_iaddr     (i_iaddr),
    .i_dreq      (i_dreq && data_peri),
    .i_daddr     (i_daddr),
    .i_dwe       (i_dwe),
    .i_dsize     (i_dsize),
    .i_dwdata    (i_dwdata),
    .i_bus_ready (mst_ready[cache_pkg::M_UNCACHED]),
    .i_bus_rdata (i_bus_rdata),
    .o_iack      (un_iack),
    .o_idata     (un_idata),
    .o_dack      (un_dack),
    .o_drdata    (un_drdata),
    .o_bus_valid (mst_valid[cache_pkg::M_UNCACHED]),
    .o_bus_req   (mst_req[cache_pkg::M_UNCACHED])
  );

  bus_arbiter u_arbiter (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_valid     (mst_valid),
    .i_req       (mst_req),
    .i_bus_ready (i_bus_ready),
    .o_ready     (mst_ready),
    .o_bus_valid (o_bus_valid),
    .o_bus_req   (o_bus_req)
  );

  // responses follow the same decode as the requests
  assign o_iack   = fetch_peri ? un_iack : ic_ack;
  assign o_idata  = fetch_peri ? un_idata : ic_data;
  assign o_dack   = data_peri ? un_dack : dc_ack;
  assign o_drdata = data_peri ? un_drdata : dc_rdata;

endmodule

// File: logic/bus_arbiter.sv
////////////////////
// fixed-priority bus arbiter
// grant stays with its owner until ready
////////////////////
`timescale 1ns/10ps

module bus_arbiter (
  input  logic                                           clk,
  input  logic                                           i_rst,
  input  logic                [cache_pkg::NUM_MASTERS-1:0] i_valid,
  input  cache_pkg::bus_req_t [cache_pkg::NUM_MASTERS-1:0] i_req,
  input  logic                                           i_bus_ready,
  output logic                [cache_pkg::NUM_MASTERS-1:0] o_ready,
  output logic                                           o_bus_valid,
  output cache_pkg::bus_req_t                            o_bus_req
);

  typedef logic [1:0] mst_t;

  logic locked_q;
  mst_t owner_q;
  mst_t pick;
  mst_t sel;

  // lowest index has the highest priority
  always_comb begin
    if (i_valid[cache_pkg::M_DCACHE]) begin
      pick = mst_t'(cache_pkg::M_DCACHE);
    end else if (i_valid[cache_pkg::M_UNCACHED]) begin
      pick = mst_t'(cache_pkg::M_UNCACHED);
    end else begin
      pick = mst_t'(cache_pkg::M_ICACHE);
    end
  end

  assign sel         = locked_q ? owner_q : pick;
  assign o_bus_valid = i_valid[sel];
  assign o_bus_req   = i_req[sel];

  always_comb begin
    o_ready = '0;
    if (o_bus_valid && i_bus_ready) begin
      o_ready[sel] = 1'b1;
    end
  end

  ////////////////////
  // grant lock

  always_ff @(posedge clk) begin
    if (i_rst) begin
      locked_q <= 1'b0;
    end else begin
      locked_q <= o_bus_valid && !i_bus_ready;
    end
  end

  // unchanged while locked since sel is the owner then
  always_ff @(posedge clk) begin
    owner_q <= sel;
  end

endmodule

// File: logic/uncached_port.sv
////////////////////
// uncached single-word access
// serves peripheral requests from both channels
////////////////////
`timescale 1ns/10ps

module uncached_port (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_ireq,
  input  cache_pkg::addr_t    i_iaddr,
  input  logic                i_dreq,
  input  cache_pkg::addr_t    i_daddr,
  input  logic                i_dwe,
  input  cache_pkg::size_e    i_dsize,
  input  cache_pkg::word_t    i_dwdata,
  input  logic                i_bus_ready,
  input  cache_pkg::line_t    i_bus_rdata,
  output logic                o_iack,
  output cache_pkg::inst_t    o_idata,
  output logic                o_dack,
  output cache_pkg::word_t    o_drdata,
  output logic                o_bus_valid,
  output cache_pkg::bus_req_t o_bus_req
);

  typedef enum logic [1:0] {IDLE, BUSY, RESP} state_e;

  state_e           state_q;
  logic             owner_d_q;
  logic             we_q;
  cache_pkg::addr_t addr_q;
  cache_pkg::word_t wdata_q;
  cache_pkg::word_t rdata_q;
  cache_pkg::strb_t strb_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (i_dreq || i_ireq) state_q <= BUSY;
        BUSY:    if (i_bus_ready) state_q <= RESP;
        default: state_q <= IDLE;
      endcase
    end
  end

  // data side wins when both ask at once
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      owner_d_q <= i_dreq;
      addr_q    <= i_dreq ? i_daddr : i_iaddr;
      we_q      <= i_dreq && i_dwe;
      wdata_q   <= i_dwdata << {i_daddr[2:0], 3'b000};
      strb_q    <= cache_pkg::size_strb(i_dsize, i_daddr[2:0]);
    end
    if ((state_q == BUSY) && i_bus_ready) begin
      rdata_q <= i_bus_rdata[63:0];
    end
  end

  assign o_iack      = (state_q == RESP) && !owner_d_q;
  assign o_dack      = (state_q == RESP) && owner_d_q;
  assign o_idata     = addr_q[2] ? rdata_q[63:32] : rdata_q[31:0];
  assign o_drdata    = rdata_q;
  assign o_bus_valid = (state_q == BUSY);

  always_comb begin
    o_bus_req.op    = we_q ? cache_pkg::BUS_WRITE : cache_pkg::BUS_READ;
    o_bus_req.addr  = {addr_q[31:3], 3'b000};
    o_bus_req.wdata = wdata_q;
    o_bus_req.wstrb = we_q ? strb_q : '0;
    o_bus_req.line  = 1'b0;
  end

endmodule

// File: logic/dcache.sv
////////////////////
// data cache, direct mapped, write through
// no allocate on write miss
////////////////////
`timescale 1ns/10ps

module dcache #(
  parameter int LINES = 16
) (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_req,
  input  cache_pkg::addr_t    i_addr,
  input  logic                i_we,
  input  cache_pkg::size_e    i_size,
  input  cache_pkg::word_t    i_wdata,
  input  logic                i_bus_ready,
  input  cache_pkg::line_t    i_bus_rdata,
  output logic                o_ack,
  output cache_pkg::word_t    o_rdata,
  output logic                o_bus_valid,
  output cache_pkg::bus_req_t o_bus_req
);

  localparam int OFF_W = $clog2(cache_pkg::LINE_BYTES);
  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = 32 - OFF_W - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef enum logic [1:0] {IDLE, REFILL, WRITE, RESP} state_e;

  state_e           state_q;
  logic [LINES-1:0] valid_q;
  tag_t             tag_q [LINES];
  cache_pkg::line_t data_q [LINES];

  idx_t             idx;
  tag_t             tag;
  logic [1:0]       wsel;
  logic             hit;
  cache_pkg::strb_t strb;
  cache_pkg::word_t wlane;

  assign idx  = i_addr[OFF_W +: IDX_W];
  assign tag  = i_addr[31 -: TAG_W];
  assign wsel = i_addr[4:3];
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);
  // store data moved into its byte lanes
  assign strb  = cache_pkg::size_strb(i_size, i_addr[2:0]);
  assign wlane = i_wdata << {i_addr[2:0], 3'b000};

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_req) begin
            if (i_we) begin
              state_q <= WRITE;
            end else begin
              state_q <= hit ? RESP : REFILL;
            end
          end
        end
        REFILL: begin
          if (i_bus_ready) begin
            valid_q[idx] <= 1'b1;
            state_q      <= RESP;
          end
        end
        WRITE:   if (i_bus_ready) state_q <= RESP;
        RESP:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && i_req) begin
      o_rdata <= data_q[idx][wsel*64 +: 64];
    end
    if ((state_q == REFILL) && i_bus_ready) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= i_bus_rdata;
      o_rdata     <= i_bus_rdata[wsel*64 +: 64];
    end
    // merge into a resident line once memory has taken the write
    if ((state_q == WRITE) && i_bus_ready && hit) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          data_q[idx][wsel*64 + b*8 +: 8] <= wlane[b*8 +: 8];
        end
      end
    end
  end

  assign o_ack       = (state_q == RESP);
  assign o_bus_valid = (state_q == REFILL) || (state_q == WRITE);

  always_comb begin
    if (state_q == WRITE) begin
      o_bus_req.op    = cache_pkg::BUS_WRITE;
      o_bus_req.addr  = {i_addr[31:3], 3'b000};
      o_bus_req.wstrb = strb;
    end else begin
      o_bus_req.op    = cache_pkg::BUS_READ;
      o_bus_req.addr  = {i_addr[31:OFF_W], {OFF_W{1'b0}}};
      o_bus_req.wstrb = '0;
    end
    o_bus_req.wdata = wlane;
    o_bus_req.line  = (state_q == REFILL);
  end

endmodule

// File: logic/icache.sv
////////////////////
// instruction cache, direct mapped, read only
// whole-line refill, fence.i drops every line
////////////////////
`timescale 1ns/10ps

module icache #(
  parameter int LINES = 16
) (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_req,
  input  cache_pkg::addr_t    i_addr,
  input  logic                i_fence_req,
  input  logic                i_bus_ready,
  input  cache_pkg::line_t    i_bus_rdata,
  output logic                o_ack,
  output cache_pkg::inst_t    o_data,
  output logic                o_fence_ack,
  output logic                o_bus_valid,
  output cache_pkg::bus_req_t o_bus_req
);

  localparam int OFF_W = $clog2(cache_pkg::LINE_BYTES);
  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = 32 - OFF_W - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef enum logic [1:0] {IDLE, REFILL, RESP} state_e;

  state_e           state_q;
  logic [LINES-1:0] valid_q;
  tag_t             tag_q [LINES];
  cache_pkg::line_t data_q [LINES];

  idx_t       idx;
  tag_t       tag;
  logic [2:0] isel;
  logic       hit;
  logic       fence_go;

  assign idx  = i_addr[OFF_W +: IDX_W];
  assign tag  = i_addr[31 -: TAG_W];
  assign isel = i_addr[4:2];
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);
  // no fence while a fetch is in progress
  assign fence_go = (state_q == IDLE) && i_fence_req && !o_fence_ack;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q     <= IDLE;
      valid_q     <= '0;
      o_fence_ack <= 1'b0;
    end else begin
      o_fence_ack <= fence_go;
      case (state_q)
        IDLE: begin
          if (fence_go) begin
            valid_q <= '0;
          end else if (i_req) begin
            state_q <= hit ? RESP : REFILL;
          end
        end
        REFILL: begin
          if (i_bus_ready) begin
            valid_q[idx] <= 1'b1;
            state_q      <= RESP;
          end
        end
        RESP:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && i_req) begin
      o_data <= data_q[idx][isel*32 +: 32];
    end
    if ((state_q == REFILL) && i_bus_ready) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= i_bus_rdata;
      o_data      <= i_bus_rdata[isel*32 +: 32];
    end
  end

  assign o_ack       = (state_q == RESP);
  assign o_bus_valid = (state_q == REFILL);

  always_comb begin
    o_bus_req.op    = cache_pkg::BUS_READ;
    o_bus_req.addr  = {i_addr[31:OFF_W], {OFF_W{1'b0}}};
    o_bus_req.wdata = '0;
    o_bus_req.wstrb = '0;
    o_bus_req.line  = 1'b1;
  end

endmodule

// File: logic/cache_pkg.sv
////////////////////
// shared types for the cache block
// widths, address map and bus request
////////////////////
package cache_pkg;

  typedef logic [31:0]  addr_t;
  typedef logic [63:0]  word_t;
  typedef logic [31:0]  inst_t;
  typedef logic [255:0] line_t;
  typedef logic [7:0]   strb_t;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {SZ_B = 2'd0, SZ_H = 2'd1, SZ_W = 2'd2, SZ_D = 2'd3} size_e;

  typedef enum logic {BUS_READ = 1'b0, BUS_WRITE = 1'b1} bus_op_e;

  typedef struct packed {
    bus_op_e op;
    addr_t   addr;
    word_t   wdata;
    strb_t   wstrb;
    logic    line;
  } bus_req_t;

  localparam int    LINE_BYTES = 32;
  localparam addr_t PERI_LO    = 32'h1000_0000;
  localparam addr_t PERI_HI    = 32'h2FFF_FFFF;
  localparam addr_t MEM_BASE   = 32'h8000_0000;

  // bus masters, lowest index wins
  localparam int NUM_MASTERS = 3;
  localparam int M_DCACHE    = 0;
  localparam int M_UNCACHED  = 1;
  localparam int M_ICACHE    = 2;

  function automatic logic in_peri(addr_t a);
    return (a >= PERI_LO) && (a <= PERI_HI);
  endfunction

  function automatic logic in_mem(addr_t a);
    return a >= MEM_BASE;
  endfunction

  // byte enables for a sized access at a word offset
  function automatic strb_t size_strb(size_e sz, logic [2:0] off);
    strb_t mask;
    case (sz)
      SZ_B:    mask = 8'h01;
      SZ_H:    mask = 8'h03;
      SZ_W:    mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return mask << off;
  endfunction

endpackage
